//--- common/gamePkg.sv
package gamePkg;

   localparam int buttonWidth = 4;    // one button and one LED per sequence index.
   localparam int addressWidth = 4;   // sixteen sequence entries.
   localparam int indexWidth = $clog2(buttonWidth);

   typedef enum logic [3:0] {
      stateIdle,
      statePrepare,
      stateStartRound,
      stateShowLed,
      stateNextLed,
      stateStartPlay,
      stateWaitMove,
      stateStoreMove,
      stateCompareMove,
      stateNextMove,
      stateEndRound,
      stateWon,
      stateLost
   } gameState_t;

   typedef struct packed {
      logic clearAddress;
      logic stepAddress;
      logic clearLimit;
      logic stepLimit;
      logic storeMove;
      logic ledOn;
      logic runLedTimer;
      logic clearLedTimer;
      logic runPlayTimer;
      logic clearPlayTimer;
   } gameCommand_t;

   typedef struct packed {
      logic addressAtLimit;
      logic limitAtLast;
      logic moveMatches;
      logic ledTimeUp;
      logic playTimeUp;
   } gameStatus_t;

endpackage

//--- src/sequenceMemory.sv
`timescale 1ns/10ps

module sequenceMemory (
   input  logic [gamePkg::addressWidth-1:0] address,
   output logic [gamePkg::indexWidth-1:0]   buttonIndex
);

   always_comb begin
      case (address)
         4'd0:    buttonIndex = 2'd0;
         4'd1:    buttonIndex = 2'd2;
         4'd2:    buttonIndex = 2'd1;
         4'd3:    buttonIndex = 2'd3;
         4'd4:    buttonIndex = 2'd3;
         4'd5:    buttonIndex = 2'd0;
         4'd6:    buttonIndex = 2'd2;
         4'd7:    buttonIndex = 2'd1;
         4'd8:    buttonIndex = 2'd1;
         4'd9:    buttonIndex = 2'd3;
         4'd10:   buttonIndex = 2'd0;
         4'd11:   buttonIndex = 2'd2;
         4'd12:   buttonIndex = 2'd2;
         4'd13:   buttonIndex = 2'd1;
         4'd14:   buttonIndex = 2'd3;
         4'd15:   buttonIndex = 2'd0;
         default: buttonIndex = 2'd0;
      endcase
   end

endmodule

//--- src/buttonPress.sv
`timescale 1ns/10ps

module buttonPress (
   input  logic                            clock,
   input  logic                            reset,
   input  logic [gamePkg::buttonWidth-1:0] buttons,
   output logic                            press,
   output logic [gamePkg::indexWidth-1:0]  pressIndex
);

   import gamePkg::*;

   logic [buttonWidth-1:0] lastButtons;
   logic                   singleButton;
   logic                   newPress;
   logic [indexWidth-1:0]  encodedIndex;

   assign singleButton = (buttons != '0) && ((buttons & (buttons - 1'b1)) == '0);
   assign newPress = singleButton && (lastButtons == '0);   // all released before this one.

   always_comb begin
      encodedIndex = '0;
      for (int i = 0; i < buttonWidth; i++) begin
         if (buttons[i]) begin
            encodedIndex = indexWidth'(i);
         end
      end
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         lastButtons <= '0;
         press <= 1'b0;
      end else begin
         lastButtons <= buttons;
         press <= newPress;
      end
   end

   always_ff @(posedge clock) begin
      if (newPress) begin
         pressIndex <= encodedIndex;   // held until the next press.
      end
   end

endmodule

//--- src/intervalTimer.sv
`timescale 1ns/10ps

module intervalTimer #(
   parameter int limit = 25
) (
   input  logic clock,
   input  logic reset,
   input  logic clear,
   input  logic run,
   output logic expired
);

   localparam int countWidth = $clog2(limit + 1);
   localparam logic [countWidth-1:0] lastCount = countWidth'(limit - 1);

   logic [countWidth-1:0] count;

   // the count stops at its last value, so expired stays up until cleared.
   assign expired = (count == lastCount);

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         count <= '0;
      end else if (clear) begin
         count <= '0;
      end else if (run && !expired) begin
         count <= count + 1'b1;
      end
   end

endmodule

//--- game/gameControl.sv
`timescale 1ns/10ps

module gameControl (
   input  logic                  clock,
   input  logic                  reset,
   input  logic                  start,
   input  logic                  press,
   input  gamePkg::gameStatus_t  status,
   output gamePkg::gameCommand_t command,
   output logic                  won,
   output logic                  lost,
   output logic                  done,
   output gamePkg::gameState_t   stateDebug
);

   import gamePkg::*;

   gameState_t state;
   gameState_t nextState;

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         state <= stateIdle;
      end else begin
         state <= nextState;
      end
   end

   always_comb begin
      nextState = state;
      case (state)
         stateIdle,
         stateWon,
         stateLost: begin
            if (start) begin
               nextState = statePrepare;
            end
         end
         statePrepare:    nextState = stateStartRound;
         stateStartRound: nextState = stateShowLed;
         stateShowLed: begin
            if (status.ledTimeUp) begin
               nextState = stateNextLed;
            end
         end
         stateNextLed: begin
            if (status.addressAtLimit) begin
               nextState = stateStartPlay;
            end else begin
               nextState = stateShowLed;
            end
         end
         stateStartPlay:  nextState = stateWaitMove;
         stateWaitMove: begin
            if (press) begin
               nextState = stateStoreMove;   // a press wins over a timeout in the same cycle.
            end else if (status.playTimeUp) begin
               nextState = stateLost;
            end
         end
         stateStoreMove:  nextState = stateCompareMove;
         stateCompareMove: begin
            if (!status.moveMatches) begin
               nextState = stateLost;
            end else if (status.addressAtLimit) begin
               nextState = stateEndRound;
            end else begin
               nextState = stateNextMove;
            end
         end
         stateNextMove:   nextState = stateWaitMove;
         stateEndRound: begin
            if (status.limitAtLast) begin
               nextState = stateWon;
            end else begin
               nextState = stateStartRound;
            end
         end
         default:         nextState = stateIdle;
      endcase
   end

   // Command decode. Each field is a pure function of the current state.
   always_comb begin
      command = '0;
      case (state)
         statePrepare: begin
            command.clearLimit = 1'b1;
         end
         stateStartRound: begin
            command.clearAddress = 1'b1;
            command.clearLedTimer = 1'b1;
         end
         stateShowLed: begin
            command.ledOn = 1'b1;
            command.runLedTimer = 1'b1;
         end
         stateNextLed: begin
            command.stepAddress = 1'b1;   // startPlay rewinds it after the last entry.
            command.clearLedTimer = 1'b1;
         end
         stateStartPlay: begin
            command.clearAddress = 1'b1;
            command.clearPlayTimer = 1'b1;
         end
         stateWaitMove: begin
            command.runPlayTimer = 1'b1;
         end
         stateStoreMove: begin
            command.storeMove = 1'b1;
         end
         stateNextMove: begin
            command.stepAddress = 1'b1;
            command.clearPlayTimer = 1'b1;
         end
         stateEndRound: begin
            command.stepLimit = 1'b1;
         end
         default: begin
            command = '0;
         end
      endcase
   end

   assign won = (state == stateWon);
   assign lost = (state == stateLost);
   assign done = won || lost;
   assign stateDebug = state;

endmodule

//--- game/gameDatapath.sv
`timescale 1ns/10ps

module gameDatapath #(
   parameter int numRounds = 16,
   parameter int ledCycles = 25,
   parameter int timeoutCycles = 100
) (
   input  logic                            clock,
   input  logic                            reset,
   input  gamePkg::gameCommand_t           command,
   input  logic                            press,
   input  logic [gamePkg::indexWidth-1:0]  pressIndex,
   output gamePkg::gameStatus_t            status,
   output logic [gamePkg::buttonWidth-1:0] leds
);

   import gamePkg::*;

   logic [addressWidth-1:0] address;
   logic [addressWidth-1:0] roundLimit;   // holds the round number minus one.
   logic [indexWidth-1:0]   storedMove;
   logic [indexWidth-1:0]   romIndex;

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         address <= '0;
         roundLimit <= '0;
      end else begin
         if (command.clearAddress) begin
            address <= '0;
         end else if (command.stepAddress) begin
            address <= address + 1'b1;
         end
         if (command.clearLimit) begin
            roundLimit <= '0;
         end else if (command.stepLimit) begin
            roundLimit <= roundLimit + 1'b1;
         end
      end
   end

   always_ff @(posedge clock) begin
      if (command.storeMove) begin
         storedMove <= pressIndex;
      end
   end

   sequenceMemory rom (
      .address(address),
      .buttonIndex(romIndex)
   );

   intervalTimer #(.limit(ledCycles)) ledTimer (
      .clock(clock),
      .reset(reset),
      .clear(command.clearLedTimer),
      .run(command.runLedTimer),
      .expired(status.ledTimeUp)
   );

   intervalTimer #(.limit(timeoutCycles)) playTimer (
      .clock(clock),
      .reset(reset),
      .clear(command.clearPlayTimer || press),
      .run(command.runPlayTimer),
      .expired(status.playTimeUp)
   );

   assign status.addressAtLimit = (address == roundLimit);
   assign status.limitAtLast = (roundLimit == addressWidth'(numRounds - 1));
   assign status.moveMatches = (storedMove == romIndex);

   always_comb begin
      leds = '0;
      if (command.ledOn) begin
         leds[romIndex] = 1'b1;
      end
   end

endmodule

//--- src/sequenceGame.sv
`timescale 1ns/10ps

module sequenceGame #(
   parameter int numRounds = 16,
   parameter int ledCycles = 25,
   parameter int timeoutCycles = 100
) (
   input  logic                            clock,
   input  logic                            reset,
   input  logic                            start,
   input  logic [gamePkg::buttonWidth-1:0] buttons,
   output logic [gamePkg::buttonWidth-1:0] leds,
   output logic                            won,
   output logic                            lost,
   output logic                            done,
   output gamePkg::gameState_t             stateDebug
);

   import gamePkg::*;

   logic                  press;
   logic [indexWidth-1:0] pressIndex;
   gameCommand_t          command;
   gameStatus_t           status;

   buttonPress pressDetect (
      .clock(clock),
      .reset(reset),
      .buttons(buttons),
      .press(press),
      .pressIndex(pressIndex)
   );

   gameControl control (
      .clock(clock),
      .reset(reset),
      .start(start),
      .press(press),
      .status(status),
      .command(command),
      .won(won),
      .lost(lost),
      .done(done),
      .stateDebug(stateDebug)
   );

   gameDatapath #(
      .numRounds(numRounds),
      .ledCycles(ledCycles),
      .timeoutCycles(timeoutCycles)
   ) datapath (
      .clock(clock),
      .reset(reset),
      .command(command),
      .press(press),
      .pressIndex(pressIndex),
      .status(status),
      .leds(leds)
   );

endmodule

//--- tests/sequenceGameTb.sv
`timescale 1ns/10ps

module sequenceGameTb;

   import gamePkg::*;

   localparam int numRounds = 4;
   localparam int ledCycles = 3;
   localparam int timeoutCycles = 20;
   localparam int cycleLimit = 6000;   // all four tests take well under a thousand cycles.

   logic                   clock;
   logic                   reset;
   logic                   start;
   logic [buttonWidth-1:0] buttons;
   logic [buttonWidth-1:0] leds;
   logic                   won;
   logic                   lost;
   logic                   done;
   gameState_t             stateDebug;

   int cycleCount = 0;
   int sequenceTable [16] = '{0, 2, 1, 3, 3, 0, 2, 1, 1, 3, 0, 2, 2, 1, 3, 0};

   sequenceGame #(
      .numRounds(numRounds),
      .ledCycles(ledCycles),
      .timeoutCycles(timeoutCycles)
   ) DUT (
      .clock(clock),
      .reset(reset),
      .start(start),
      .buttons(buttons),
      .leds(leds),
      .won(won),
      .lost(lost),
      .done(done),
      .stateDebug(stateDebug)
   );

   always #20 clock = ~clock;

   always @(posedge clock) begin
      cycleCount = cycleCount + 1;
      if (cycleCount >= cycleLimit) begin
         $display("Timeout: the tests did not finish within %0d clock cycles.", cycleLimit);
         stopRun();
      end
   end

   task automatic stopRun();
      $display("Some tests failed");
      $fatal(1, "simulation stopped at the first error.");
   endtask

   function automatic logic [buttonWidth-1:0] oneHot(input int index);
      return buttonWidth'(1) << index;
   endfunction

   task automatic checkLeds(input logic [buttonWidth-1:0] actual,
                            input logic [buttonWidth-1:0] expected, input string what);
      if (actual !== expected) begin
         $display("FAIL at %0d ns: %s, leds %b, expected %b", $time, what, actual, expected);
         stopRun();
      end
   endtask

   task automatic checkFlags(input logic wonSeen, input logic lostSeen, input logic doneSeen,
                             input logic wonWant, input logic lostWant, input logic doneWant,
                             input string what);
      if ({wonSeen, lostSeen, doneSeen} !== {wonWant, lostWant, doneWant}) begin
         $display("FAIL at %0d ns: %s, won/lost/done %b%b%b, expected %b%b%b", $time, what,
                  wonSeen, lostSeen, doneSeen, wonWant, lostWant, doneWant);
         stopRun();
      end
   endtask

   task automatic checkState(input gameState_t actual, input gameState_t expected,
                             input string what);
      if (actual !== expected) begin
         $display("FAIL at %0d ns: %s, state %s, expected %s", $time, what, actual.name(),
                  expected.name());
         stopRun();
      end
   endtask

   task automatic waitForState(input gameState_t target);
      while (stateDebug !== target) begin
         @(negedge clock);
      end
   endtask

   task automatic waitForDone();
      while (done !== 1'b1) begin
         @(negedge clock);
      end
   endtask

   task automatic startGame();
      start = 1'b1;   // sampled in idle, won or lost.
      @(negedge clock);
      start = 1'b0;
   endtask

   task automatic watchShow(input int round);
      while (leds === '0) begin
         @(negedge clock);
      end
      for (int entry = 0; entry < round; entry++) begin
         for (int cycle = 0; cycle < ledCycles; cycle++) begin
            checkLeds(leds, oneHot(sequenceTable[entry]),
                      $sformatf("round %0d entry %0d", round, entry));
            @(negedge clock);
         end
         checkLeds(leds, '0, $sformatf("dark cycle after round %0d entry %0d", round, entry));
         @(negedge clock);
      end
      checkState(stateDebug, stateStartPlay, $sformatf("end of round %0d display", round));
   endtask

   task automatic pressButton(input int index);
      waitForState(stateWaitMove);
      buttons = oneHot(index);
      repeat (2) @(negedge clock);
      buttons = '0;
      repeat (2) @(negedge clock);
   endtask

   task automatic playRound(input int round);
      watchShow(round);
      for (int entry = 0; entry < round; entry++) begin
         pressButton(sequenceTable[entry]);
      end
   endtask

   task automatic testReset();
      checkLeds(leds, '0, "leds after reset");
      checkFlags(won, lost, done, 1'b0, 1'b0, 1'b0, "flags after reset");
      checkState(stateDebug, stateIdle, "state after reset");
   endtask

   task automatic testWinGame();
      startGame();
      for (int round = 1; round <= numRounds; round++) begin
         playRound(round);
      end
      waitForDone();
      checkFlags(won, lost, done, 1'b1, 1'b0, 1'b1, "after all rounds played correctly");
      checkState(stateDebug, stateWon, "after all rounds played correctly");
      checkLeds(leds, '0, "leds after a won game");
   endtask

   task automatic testWrongButton();
      startGame();
      playRound(1);
      playRound(2);
      watchShow(3);
      pressButton(sequenceTable[0]);
      pressButton((sequenceTable[1] + 1) % buttonWidth);   // any index but the right one.
      waitForDone();
      checkFlags(won, lost, done, 1'b0, 1'b1, 1'b1, "after a wrong button in round 3");
      checkState(stateDebug, stateLost, "after a wrong button in round 3");
   endtask

   task automatic testTimeoutRestart();
      startGame();
      watchShow(1);
      @(negedge clock);
      for (int cycle = 0; cycle < timeoutCycles; cycle++) begin
         checkState(stateDebug, stateWaitMove, $sformatf("cycle %0d without a press", cycle));
         @(negedge clock);
      end
      checkState(stateDebug, stateLost, "after the play timeout");
      checkFlags(won, lost, done, 1'b0, 1'b1, 1'b1, "after the play timeout");
      startGame();
      checkFlags(won, lost, done, 1'b0, 1'b0, 1'b0, "after a restart from lost");
      watchShow(1);   // the new game starts again at entry 0.
   endtask

   initial begin
      clock = 1'b0;
      reset = 1'b1;
      start = 1'b0;
      buttons = '0;
      repeat (16) @(negedge clock);
      reset = 1'b0;
      @(negedge clock);
      testReset();
      testWinGame();
      testWrongButton();
      testTimeoutRestart();
      $display("All tests passed");
      $finish;
   end

endmodule

//--- verilog.f
common/gamePkg.sv
src/sequenceMemory.sv
src/buttonPress.sv
src/intervalTimer.sv
game/gameControl.sv
game/gameDatapath.sv
src/sequenceGame.sv
tests/sequenceGameTb.sv

//--- Makefile
TB = sequenceGameTb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module sequenceGame -f verilog.f

sim:
	verilator --binary --timing --top-module $(TB) -f verilog.f
	@out="$$(./obj_dir/V$(TB))"; echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
